/* src/blimp_pkg.sv */
//--------------------------------------
// Shared core definitions: word and
// register index widths, major opcodes,
// funct fields, decoded operation type
//--------------------------------------

package blimp_pkg;

  //--------------------------------------
  // Widths
  //--------------------------------------

  // Data and address width
  localparam int xlen = 32;

  // Register index width, 32 registers
  localparam int reg_addr_bits = 5;

  //--------------------------------------
  // Encodings
  //--------------------------------------

  // Register-register arithmetic (add, mul)
  localparam logic [6:0] opcode_op = 7'b0110011;

  // Register-immediate arithmetic (addi)
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  // Add, addi and mul all share this funct3
  localparam logic [2:0] funct3_add = 3'b000;

  // Plain add
  localparam logic [6:0] funct7_add = 7'b0000000;

  // M extension selector, mul in this subset
  localparam logic [6:0] funct7_mul = 7'b0000001;

  //--------------------------------------
  // Decoded operation
  //--------------------------------------

  // What execute does with an issued instruction
  // op_nop retires with no register write
  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_mul = 2'd1,
    op_nop = 2'd2
  } alu_op_e;

endpackage

/* src/inst_fetch.sv */
//--------------------------------------
// Fetch unit: tagged memory requests,
// in-flight limit, in-order buffer of
// returned instructions with their PCs
//--------------------------------------

`timescale 1ns/1ps

module inst_fetch #(
  parameter int p_opaq_bits    = 8,
  parameter int p_seq_num_bits = 3
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // Memory request
  output logic                       imem_req_val,
  input  logic                       imem_req_rdy,
  output logic [blimp_pkg::xlen-1:0] imem_req_addr,
  output logic [p_opaq_bits-1:0]     imem_req_opaque,
  // Memory response
  input  logic                       imem_resp_val,
  output logic                       imem_resp_rdy,
  input  logic [blimp_pkg::xlen-1:0] imem_resp_data,
  input  logic [p_opaq_bits-1:0]     imem_resp_opaque,
  // Head of buffer toward decode
  output logic                       fetch_val,
  output logic [blimp_pkg::xlen-1:0] fetch_inst,
  output logic [blimp_pkg::xlen-1:0] fetch_pc,
  input  logic                       fetch_deq
);
  import blimp_pkg::*;

  localparam int depth = 2 ** p_seq_num_bits;
  localparam logic [p_seq_num_bits:0] cnt_full = (p_seq_num_bits + 1)'(depth);
  localparam logic [p_seq_num_bits:0] cnt_one = (p_seq_num_bits + 1)'(1);
  localparam logic [p_seq_num_bits-1:0] seq_one = p_seq_num_bits'(1);

  // Sequence numbers double as buffer slot indices
  logic [p_seq_num_bits-1:0] req_seq;
  logic [p_seq_num_bits-1:0] resp_seq;
  logic [p_seq_num_bits-1:0] head;

  // Outstanding requests and filled slots
  logic [p_seq_num_bits:0]   inflight;
  logic [p_seq_num_bits:0]   buf_cnt;
  logic [p_seq_num_bits:0]   inflight_n;
  logic [p_seq_num_bits:0]   buf_cnt_n;
  logic [p_seq_num_bits:0]   total_n;

  logic                      req_fire;
  logic                      resp_fire;
  logic                      resp_ok;

  logic [xlen-1:0]           pc_buf   [depth];
  logic [xlen-1:0]           inst_buf [depth];

  //--------------------------------------
  // Handshakes
  //--------------------------------------

  assign req_fire        = imem_req_val && imem_req_rdy;
  assign resp_fire       = imem_resp_val && imem_resp_rdy;
  assign imem_req_opaque = p_opaq_bits'(req_seq);
  assign imem_resp_rdy   = (buf_cnt < cnt_full);

  // Out-of-order tag is dropped
  assign resp_ok = resp_fire && (imem_resp_opaque == p_opaq_bits'(resp_seq));

  // Next occupancy, reserved slots included
  always_comb begin
    inflight_n = inflight;
    buf_cnt_n  = buf_cnt;
    if (req_fire)
      inflight_n = inflight_n + cnt_one;
    if (resp_ok) begin
      inflight_n = inflight_n - cnt_one;
      buf_cnt_n  = buf_cnt_n + cnt_one;
    end
    if (fetch_deq)
      buf_cnt_n = buf_cnt_n - cnt_one;
    total_n = inflight_n + buf_cnt_n;
  end

  //--------------------------------------
  // Control state
  //--------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      imem_req_val  <= 1'b0;
      imem_req_addr <= '0;
      req_seq       <= '0;
      resp_seq      <= '0;
      head          <= '0;
      inflight      <= '0;
      buf_cnt       <= '0;
    end else begin
      // Stays high until accepted, counts only grow on a transfer
      imem_req_val <= (inflight_n < cnt_full) && (total_n < cnt_full);
      inflight     <= inflight_n;
      buf_cnt      <= buf_cnt_n;
      if (req_fire) begin
        imem_req_addr <= imem_req_addr + 32'd4;
        req_seq       <= req_seq + seq_one;
      end
      if (resp_ok)
        resp_seq <= resp_seq + seq_one;
      if (fetch_deq)
        head <= head + seq_one;
    end
  end

  //--------------------------------------
  // Buffer storage
  //--------------------------------------

  // PC lands at request time, instruction at response time
  always_ff @(posedge clk) begin
    if (req_fire)
      pc_buf[req_seq] <= imem_req_addr;
    if (resp_ok)
      inst_buf[resp_seq] <= imem_resp_data;
  end

  assign fetch_val  = (buf_cnt != '0);
  assign fetch_inst = inst_buf[head];
  assign fetch_pc   = pc_buf[head];

endmodule

/* src/inst_decode.sv */
//--------------------------------------
// Decode stage: field split, operand
// read, one registered issue at a time
//--------------------------------------

`timescale 1ns/1ps

module inst_decode (
  input  logic                                clk,
  input  logic                                rst_n,
  // Fetch buffer head
  input  logic                                fetch_val,
  input  logic [blimp_pkg::xlen-1:0]          fetch_inst,
  input  logic [blimp_pkg::xlen-1:0]          fetch_pc,
  output logic                                fetch_deq,
  // Register file read ports
  output logic [blimp_pkg::reg_addr_bits-1:0] rs1_addr,
  output logic [blimp_pkg::reg_addr_bits-1:0] rs2_addr,
  input  logic [blimp_pkg::xlen-1:0]          rs1_data,
  input  logic [blimp_pkg::xlen-1:0]          rs2_data,
  // Issue toward execute
  input  logic                                exec_busy,
  output logic                                issue_val,
  output blimp_pkg::alu_op_e                  issue_op,
  output logic [blimp_pkg::xlen-1:0]          issue_pc,
  output logic [blimp_pkg::reg_addr_bits-1:0] issue_waddr,
  output logic                                issue_wen,
  output logic [blimp_pkg::xlen-1:0]          issue_a,
  output logic [blimp_pkg::xlen-1:0]          issue_b
);
  import blimp_pkg::*;

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [reg_addr_bits-1:0] rd;
  logic [xlen-1:0]          imm;
  alu_op_e                  dec_op;
  logic                     use_imm;

  //--------------------------------------
  // Field extraction
  //--------------------------------------

  assign opcode   = fetch_inst[6:0];
  assign rd       = fetch_inst[11:7];
  assign funct3   = fetch_inst[14:12];
  assign rs1_addr = fetch_inst[19:15];
  assign rs2_addr = fetch_inst[24:20];
  assign funct7   = fetch_inst[31:25];

  // I-type immediate, sign extended
  assign imm = {{(xlen - 12){fetch_inst[31]}}, fetch_inst[31:20]};

  // Anything unrecognised falls through as a no-op
  always_comb begin
    dec_op  = op_nop;
    use_imm = 1'b0;
    if (funct3 == funct3_add) begin
      if (opcode == opcode_op && funct7 == funct7_add) begin
        dec_op = op_add;
      end else if (opcode == opcode_op && funct7 == funct7_mul) begin
        dec_op = op_mul;
      end else if (opcode == opcode_op_imm) begin
        dec_op  = op_add;
        use_imm = 1'b1;
      end
    end
  end

  // Take the head only while execute is idle
  assign fetch_deq = fetch_val && !exec_busy;

  //--------------------------------------
  // Issue registers
  //--------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      issue_val <= 1'b0;
    else
      issue_val <= fetch_deq;
  end

  always_ff @(posedge clk) begin
    if (fetch_deq) begin
      issue_op    <= dec_op;
      issue_pc    <= fetch_pc;
      issue_waddr <= rd;
      // x0 and no-ops never write
      issue_wen   <= (dec_op != op_nop) && (rd != '0);
      issue_a     <= rs1_data;
      issue_b     <= use_imm ? imm : rs2_data;
    end
  end

endmodule

/* src/reg_file.sv */
//--------------------------------------
// Integer register file, 2R/1W,
// x0 reads as zero
//--------------------------------------

`timescale 1ns/1ps

module reg_file (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [blimp_pkg::reg_addr_bits-1:0] rs1_addr,
  input  logic [blimp_pkg::reg_addr_bits-1:0] rs2_addr,
  output logic [blimp_pkg::xlen-1:0]          rs1_data,
  output logic [blimp_pkg::xlen-1:0]          rs2_data,
  input  logic                                rf_wen,
  input  logic [blimp_pkg::reg_addr_bits-1:0] rf_waddr,
  input  logic [blimp_pkg::xlen-1:0]          rf_wdata
);
  import blimp_pkg::*;

  localparam int num_regs = 2 ** reg_addr_bits;

  // No storage behind x0
  logic [xlen-1:0] regs [1:num_regs-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < num_regs; i++)
        regs[i] <= '0;
    end else if (rf_wen && rf_waddr != '0) begin
      regs[rf_waddr] <= rf_wdata;
    end
  end

  // Combinational reads
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* src/int_execute.sv */
//--------------------------------------
// Execute stage: one-cycle add, 32-step
// shift-add multiply, writeback, trace
//--------------------------------------

`timescale 1ns/1ps

module int_execute (
  input  logic                                clk,
  input  logic                                rst_n,
  // Issued operation
  input  logic                                issue_val,
  input  blimp_pkg::alu_op_e                  issue_op,
  input  logic [blimp_pkg::xlen-1:0]          issue_pc,
  input  logic [blimp_pkg::reg_addr_bits-1:0] issue_waddr,
  input  logic                                issue_wen,
  input  logic [blimp_pkg::xlen-1:0]          issue_a,
  input  logic [blimp_pkg::xlen-1:0]          issue_b,
  output logic                                exec_busy,
  // Register write port
  output logic                                rf_wen,
  output logic [blimp_pkg::reg_addr_bits-1:0] rf_waddr,
  output logic [blimp_pkg::xlen-1:0]          rf_wdata,
  // Retirement trace
  output logic                                trace_val,
  output logic [blimp_pkg::xlen-1:0]          trace_pc,
  output logic [blimp_pkg::reg_addr_bits-1:0] trace_waddr,
  output logic [blimp_pkg::xlen-1:0]          trace_wdata,
  output logic                                trace_wen
);
  import blimp_pkg::*;

  localparam int step_bits = $clog2(xlen);
  localparam logic [step_bits-1:0] last_cnt = step_bits'(xlen - 1);
  localparam logic [step_bits-1:0] step_one = step_bits'(1);

  logic                     mul_active;
  logic [step_bits-1:0]     step_cnt;
  logic                     last_step;
  logic                     fast_wb;

  // Multiplier datapath
  logic [xlen-1:0]          acc;
  logic [xlen-1:0]          acc_next;
  logic [xlen-1:0]          mcand;
  logic [xlen-1:0]          mplr;

  // Held while the multiply runs
  logic [xlen-1:0]          op_pc;
  logic [reg_addr_bits-1:0] op_waddr;
  logic                     op_wen;

  // Add and no-op retire straight from issue
  assign fast_wb   = issue_val && (issue_op != op_mul);
  assign last_step = mul_active && (step_cnt == last_cnt);

  // Busy from issue through the writeback cycle
  assign exec_busy = issue_val || mul_active || trace_val;

  // One shift-add step, low word only
  assign acc_next = mplr[0] ? acc + mcand : acc;

  //--------------------------------------
  // Control
  //--------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mul_active <= 1'b0;
      step_cnt   <= '0;
      trace_val  <= 1'b0;
    end else begin
      trace_val <= fast_wb || last_step;
      if (issue_val && issue_op == op_mul) begin
        mul_active <= 1'b1;
        step_cnt   <= '0;
      end else if (mul_active) begin
        step_cnt <= step_cnt + step_one;
        if (last_step)
          mul_active <= 1'b0;
      end
    end
  end

  //--------------------------------------
  // Datapath and writeback
  //--------------------------------------

  always_ff @(posedge clk) begin
    if (issue_val) begin
      op_pc    <= issue_pc;
      op_waddr <= issue_waddr;
      op_wen   <= issue_wen;
      acc      <= '0;
      mcand    <= issue_a;
      mplr     <= issue_b;
    end else if (mul_active) begin
      acc   <= acc_next;
      mcand <= mcand << 1;
      mplr  <= mplr >> 1;
    end

    if (fast_wb) begin
      trace_pc    <= issue_pc;
      trace_waddr <= issue_waddr;
      trace_wen   <= issue_wen;
      trace_wdata <= (issue_op == op_add) ? issue_a + issue_b : '0;
    end else if (last_step) begin
      // Final step folds into the written value
      trace_pc    <= op_pc;
      trace_waddr <= op_waddr;
      trace_wen   <= op_wen;
      trace_wdata <= acc_next;
    end
  end

  // Register write lines up with the trace pulse
  assign rf_wen   = trace_val && trace_wen;
  assign rf_waddr = trace_waddr;
  assign rf_wdata = trace_wdata;

endmodule

/* src/blimp_core.sv */
//--------------------------------------
// Core top: fetch, decode, register
// file and execute stage wiring
//--------------------------------------

`timescale 1ns/1ps

module blimp_core #(
  parameter int p_opaq_bits    = 8,
  parameter int p_seq_num_bits = 3
) (
  input  logic                                clk,
  input  logic                                rst_n,
  // Instruction memory request
  output logic                                imem_req_val,
  input  logic                                imem_req_rdy,
  output logic [blimp_pkg::xlen-1:0]          imem_req_addr,
  output logic [p_opaq_bits-1:0]              imem_req_opaque,
  // Instruction memory response
  input  logic                                imem_resp_val,
  output logic                                imem_resp_rdy,
  input  logic [blimp_pkg::xlen-1:0]          imem_resp_data,
  input  logic [p_opaq_bits-1:0]              imem_resp_opaque,
  // Retirement trace
  output logic                                trace_val,
  output logic [blimp_pkg::xlen-1:0]          trace_pc,
  output logic [blimp_pkg::reg_addr_bits-1:0] trace_waddr,
  output logic [blimp_pkg::xlen-1:0]          trace_wdata,
  output logic                                trace_wen
);
  import blimp_pkg::*;

  // Fetch to decode
  logic                     fetch_val;
  logic [xlen-1:0]          fetch_inst;
  logic [xlen-1:0]          fetch_pc;
  logic                     fetch_deq;

  // Decode to register file
  logic [reg_addr_bits-1:0] rs1_addr;
  logic [reg_addr_bits-1:0] rs2_addr;
  logic [xlen-1:0]          rs1_data;
  logic [xlen-1:0]          rs2_data;

  // Decode to execute
  logic                     issue_val;
  alu_op_e                  issue_op;
  logic [xlen-1:0]          issue_pc;
  logic [reg_addr_bits-1:0] issue_waddr;
  logic                     issue_wen;
  logic [xlen-1:0]          issue_a;
  logic [xlen-1:0]          issue_b;
  logic                     exec_busy;

  // Execute writeback
  logic                     rf_wen;
  logic [reg_addr_bits-1:0] rf_waddr;
  logic [xlen-1:0]          rf_wdata;

  //--------------------------------------
  // Stages
  //--------------------------------------

  inst_fetch #(
    .p_opaq_bits    (p_opaq_bits),
    .p_seq_num_bits (p_seq_num_bits)
  ) u_fetch (
    .clk, .rst_n,
    .imem_req_val, .imem_req_rdy, .imem_req_addr, .imem_req_opaque,
    .imem_resp_val, .imem_resp_rdy, .imem_resp_data, .imem_resp_opaque,
    .fetch_val, .fetch_inst, .fetch_pc, .fetch_deq
  );

  inst_decode u_decode (
    .clk, .rst_n,
    .fetch_val, .fetch_inst, .fetch_pc, .fetch_deq,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .exec_busy,
    .issue_val, .issue_op, .issue_pc, .issue_waddr, .issue_wen,
    .issue_a, .issue_b
  );

  reg_file u_rf (
    .clk, .rst_n,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .rf_wen, .rf_waddr, .rf_wdata
  );

  int_execute u_exec (
    .clk, .rst_n,
    .issue_val, .issue_op, .issue_pc, .issue_waddr, .issue_wen,
    .issue_a, .issue_b, .exec_busy,
    .rf_wen, .rf_waddr, .rf_wdata,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen
  );

endmodule

/* dv/blimp_properties.sv */
//--------------------------------------
// Bound checks: memory request hold,
// in-order response tags, trace pulse
//--------------------------------------

`timescale 1ns/1ps

module blimp_properties #(
  parameter int p_opaq_bits    = 8,
  parameter int p_seq_num_bits = 3
) (
  input logic                                clk,
  input logic                                rst_n,
  input logic                                imem_req_val,
  input logic                                imem_req_rdy,
  input logic [blimp_pkg::xlen-1:0]          imem_req_addr,
  input logic [p_opaq_bits-1:0]              imem_req_opaque,
  input logic                                imem_resp_val,
  input logic                                imem_resp_rdy,
  input logic [p_opaq_bits-1:0]              imem_resp_opaque,
  input logic                                trace_val,
  input logic [blimp_pkg::reg_addr_bits-1:0] trace_waddr,
  input logic                                trace_wen
);

  // Next tag memory should return
  logic [p_seq_num_bits-1:0] exp_seq;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      exp_seq <= '0;
    else if (imem_resp_val && imem_resp_rdy)
      exp_seq <= exp_seq + p_seq_num_bits'(1);
  end

  // Stalled request keeps address and tag
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_val && !imem_req_rdy |=>
      imem_req_val && $stable(imem_req_addr) && $stable(imem_req_opaque))
    else $error("request dropped or changed before acceptance");

  resp_in_order: assert property (@(posedge clk) disable iff (!rst_n)
    imem_resp_val && imem_resp_rdy |-> imem_resp_opaque == p_opaq_bits'(exp_seq))
    else $error("response tag out of sequence");

  trace_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val |=> !trace_val)
    else $error("trace valid longer than one cycle");

  trace_x0: assert property (@(posedge clk) disable iff (!rst_n)
    trace_val && trace_waddr == '0 |-> !trace_wen)
    else $error("trace write enable high for x0");

endmodule

bind blimp_core blimp_properties #(
  .p_opaq_bits    (p_opaq_bits),
  .p_seq_num_bits (p_seq_num_bits)
) u_props (
  .clk              (clk),
  .rst_n            (rst_n),
  .imem_req_val     (imem_req_val),
  .imem_req_rdy     (imem_req_rdy),
  .imem_req_addr    (imem_req_addr),
  .imem_req_opaque  (imem_req_opaque),
  .imem_resp_val    (imem_resp_val),
  .imem_resp_rdy    (imem_resp_rdy),
  .imem_resp_opaque (imem_resp_opaque),
  .trace_val        (trace_val),
  .trace_waddr      (trace_waddr),
  .trace_wen        (trace_wen)
);

/* dv/blimp_tb.sv */
//--------------------------------------
// Core testbench: clock, reset, in-order
// instruction memory, trace capture,
// reference model and directed tests
//--------------------------------------

`timescale 1ns/1ps

module blimp_tb;
  import blimp_pkg::*;

  localparam int p_opaq_bits    = 8;
  localparam int p_seq_num_bits = 2;
  localparam int depth          = 2 ** p_seq_num_bits;
  localparam int mem_words      = 256;
  localparam int wait_limit     = 4000;

  logic                     clk;
  logic                     rst_n;
  logic                     imem_req_val;
  logic                     imem_req_rdy;
  logic [xlen-1:0]          imem_req_addr;
  logic [p_opaq_bits-1:0]   imem_req_opaque;
  logic                     imem_resp_val;
  logic                     imem_resp_rdy;
  logic [xlen-1:0]          imem_resp_data;
  logic [p_opaq_bits-1:0]   imem_resp_opaque;
  logic                     trace_val;
  logic [xlen-1:0]          trace_pc;
  logic [reg_addr_bits-1:0] trace_waddr;
  logic [xlen-1:0]          trace_wdata;
  logic                     trace_wen;

  // Memory model state
  logic [31:0]              imem [mem_words];
  logic [31:0]              pend_data [$];
  logic [p_opaq_bits-1:0]   pend_tag [$];
  int                       pend_due [$];
  int                       cycle_cnt;
  int                       max_inflight;
  bit                       rand_delays;

  // Handshakes seen at the falling edge
  bit                       req_fire_s;
  bit                       resp_fire_s;
  logic [31:0]              req_addr_s;
  logic [p_opaq_bits-1:0]   req_tag_s;

  // Captured trace records
  logic [31:0]              tr_pc [$];
  logic [4:0]               tr_waddr [$];
  logic [31:0]              tr_wdata [$];
  logic                     tr_wen [$];
  int                       tr_cyc [$];

  logic [31:0]              prog [$];
  logic [31:0]              ref_regs [32];

  blimp_core #(
    .p_opaq_bits    (p_opaq_bits),
    .p_seq_num_bits (p_seq_num_bits)
  ) uut (
    .clk, .rst_n,
    .imem_req_val, .imem_req_rdy, .imem_req_addr, .imem_req_opaque,
    .imem_resp_val, .imem_resp_rdy, .imem_resp_data, .imem_resp_opaque,
    .trace_val, .trace_pc, .trace_waddr, .trace_wdata, .trace_wen
  );

  always #10 clk = ~clk;

  //--------------------------------------
  // Instruction memory model
  //--------------------------------------

  // Sample handshakes and trace mid-cycle, where all are stable
  always @(negedge clk) begin
    req_fire_s  = imem_req_val && imem_req_rdy;
    req_addr_s  = imem_req_addr;
    req_tag_s   = imem_req_opaque;
    resp_fire_s = imem_resp_val && imem_resp_rdy;
    if (trace_val) begin
      tr_pc.push_back(trace_pc);
      tr_waddr.push_back(trace_waddr);
      tr_wdata.push_back(trace_wdata);
      tr_wen.push_back(trace_wen);
      tr_cyc.push_back(cycle_cnt);
    end
  end

  // In-order response queue, each entry due after a delay
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (!rst_n) begin
      pend_data.delete();
      pend_tag.delete();
      pend_due.delete();
      imem_req_rdy  <= 1'b0;
      imem_resp_val <= 1'b0;
    end else begin
      if (resp_fire_s) begin
        void'(pend_data.pop_front());
        void'(pend_tag.pop_front());
        void'(pend_due.pop_front());
      end
      if (req_fire_s) begin
        pend_data.push_back(imem[req_addr_s[9:2]]);
        pend_tag.push_back(req_tag_s);
        pend_due.push_back(cycle_cnt + (rand_delays ? int'($urandom_range(0, 5)) : 0));
      end
      if (pend_data.size() > max_inflight)
        max_inflight = pend_data.size();
      // Random request back-pressure, one cycle in four
      imem_req_rdy <= rand_delays ? ($urandom_range(0, 3) != 0) : 1'b1;
      if (pend_data.size() != 0 && pend_due[0] <= cycle_cnt) begin
        imem_resp_val    <= 1'b1;
        imem_resp_data   <= pend_data[0];
        imem_resp_opaque <= pend_tag[0];
      end else begin
        imem_resp_val <= 1'b0;
      end
    end
  end

  //--------------------------------------
  // Encoders and checks
  //--------------------------------------

  function automatic logic [31:0] add_word(input logic [4:0] rd, rs1, rs2);
    return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  function automatic logic [31:0] mul_word(input logic [4:0] rd, rs1, rs2);
    return {7'h01, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1, input int imm);
    return {imm[11:0], rs1, 3'b000, rd, 7'h13};
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic wait_traces(input int n);
    int waited;
    waited = 0;
    while (tr_pc.size() < n) begin
      @(posedge clk);
      waited++;
      if (waited > wait_limit) begin
        $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                 tr_pc.size(), n, wait_limit);
        $display("test failed");
        $fatal(1);
      end
    end
  endtask

  // Reference model walks the program in PC order
  task automatic check_traces(input int n);
    logic [31:0] inst;
    logic [31:0] res;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    bit          known;
    bit          is_mul;
    bit          wen;
    for (int r = 0; r < 32; r++)
      ref_regs[r] = '0;
    for (int i = 0; i < n; i++) begin
      inst   = imem[i];
      rd     = inst[11:7];
      a      = ref_regs[inst[19:15]];
      b      = ref_regs[inst[24:20]];
      known  = 1'b0;
      is_mul = 1'b0;
      res    = '0;
      if (inst[6:0] == 7'h33 && inst[14:12] == 3'b000 && inst[31:25] == 7'h00) begin
        known = 1'b1;
        res   = a + b;
      end else if (inst[6:0] == 7'h33 && inst[14:12] == 3'b000 && inst[31:25] == 7'h01) begin
        known  = 1'b1;
        is_mul = 1'b1;
        res    = a * b;
      end else if (inst[6:0] == 7'h13 && inst[14:12] == 3'b000) begin
        known = 1'b1;
        res   = a + {{20{inst[31]}}, inst[31:20]};
      end
      wen = known && (rd != 5'd0);
      compare("trace_pc", tr_pc[i], 32'(i * 4));
      compare("trace_waddr", 32'(tr_waddr[i]), 32'(rd));
      compare("trace_wen", 32'(tr_wen[i]), 32'(wen));
      if (wen) begin
        compare("trace_wdata", tr_wdata[i], res);
        ref_regs[rd] = res;
      end
      // Multiply spends its 32 steps in execute
      if (is_mul && i > 0)
        compare("mul_trace_gap_ok", 32'(tr_cyc[i] - tr_cyc[i-1] >= 33), 32'd1);
    end
  endtask

  //--------------------------------------
  // Program load and run
  //--------------------------------------

  task automatic run_program();
    @(posedge clk);
    rst_n <= 1'b0;
    // Unused words hold an unknown opcode tagged by index
    for (int i = 0; i < mem_words; i++)
      imem[i] = (i < prog.size()) ? prog[i] : {25'(i), 7'h7f};
    tr_pc.delete();
    tr_waddr.delete();
    tr_wdata.delete();
    tr_wen.delete();
    tr_cyc.delete();
    max_inflight = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    wait_traces(prog.size());
    check_traces(prog.size());
  endtask

  task automatic load_add_chain();
    prog = {addi_word(1, 0, 5), addi_word(2, 1, -3), add_word(3, 1, 2),
            addi_word(4, 3, 2047), add_word(5, 4, 4), addi_word(6, 5, -2048),
            add_word(7, 6, 1), add_word(8, 7, 3)};
  endtask

  task automatic test_add_chain();
    rand_delays = 1'b0;
    load_add_chain();
    run_program();
  endtask

  // Negative operands, then squares until the product overflows
  task automatic test_mul();
    rand_delays = 1'b0;
    prog = {addi_word(1, 0, -7), addi_word(2, 0, 13), mul_word(3, 1, 2),
            addi_word(4, 0, -1), mul_word(5, 4, 1), addi_word(6, 0, 2047),
            mul_word(7, 6, 6), mul_word(8, 7, 7), mul_word(9, 8, 4),
            add_word(10, 9, 8)};
    run_program();
  endtask

  task automatic test_x0();
    rand_delays = 1'b0;
    prog = {addi_word(0, 0, 5), addi_word(1, 0, 9), add_word(0, 1, 1),
            add_word(2, 0, 0), mul_word(0, 1, 1), add_word(3, 0, 1)};
    run_program();
  endtask

  // ecall, sll and sub are outside the subset
  task automatic test_nop();
    rand_delays = 1'b0;
    prog = {addi_word(1, 0, 3), 32'h0000_0073, addi_word(2, 1, 4),
            {7'h00, 5'd1, 5'd1, 3'b001, 5'd3, 7'h33}, add_word(4, 2, 1),
            {7'h20, 5'd2, 5'd1, 3'b000, 5'd5, 7'h33}, 32'hffff_ffff, addi_word(6, 4, 1)};
    run_program();
  endtask

  task automatic test_back_pressure();
    rand_delays = 1'b1;
    load_add_chain();
    run_program();
    compare("inflight_within_limit", 32'(max_inflight <= depth), 32'd1);
  endtask

  // Reset lands while requests are still outstanding
  task automatic test_reset_restart();
    rand_delays = 1'b1;
    load_add_chain();
    run_program();
    wait_traces(prog.size() + 3);
    run_program();
  endtask

  initial begin
    clk              = 1'b0;
    rst_n            = 1'b0;
    imem_req_rdy     = 1'b0;
    imem_resp_val    = 1'b0;
    imem_resp_data   = '0;
    imem_resp_opaque = '0;
    cycle_cnt        = 0;
    max_inflight     = 0;
    rand_delays      = 1'b0;
    void'($urandom(32'hd2b2_cbd0));
    test_add_chain();
    test_mul();
    test_x0();
    test_nop();
    test_back_pressure();
    test_reset_restart();
    $display("test passed");
    $finish;
  end

endmodule

/* list.f */
src/blimp_pkg.sv
src/inst_fetch.sv
src/inst_decode.sv
src/reg_file.sv
src/int_execute.sv
src/blimp_core.sv
dv/blimp_properties.sv
dv/blimp_tb.sv

/* run.sh */
#!/bin/sh
# Build the core testbench with Verilator, run it, and scan the log
rm -rf obj_dir sim.log
verilator --binary --assert --top-module blimp_tb -f list.f -o blimp_sim \
  && ./obj_dir/blimp_sim > sim.log 2>&1 \
  || echo "test failed" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0
